// ==== hw/pit_mode_pkg.sv ====
//--------------------------------------------------------------------------
// PIT mode definitions
// Counter modes, read/load formats and the byte sequencing state used by
// the counter channels of the interval timer
//--------------------------------------------------------------------------

package pit_mode_pkg;

	// counter mode from control word bits 3..1
	typedef enum logic [2:0] {
		mode_int_tc    = 3'd0,	// interrupt on terminal count
		mode_one_shot  = 3'd1,	// gate triggered, parked high here
		mode_rate      = 3'd2,	// rate generator
		mode_square    = 3'd3,	// square wave generator
		mode_sw_strobe = 3'd4,	// software triggered strobe
		mode_hw_strobe = 3'd5	// gate triggered, parked high here
	} pit_mode_t;

	// read/load format from control word bits 5..4
	typedef enum logic [1:0] {
		rl_latch = 2'd0,	// counter latch command
		rl_lsb   = 2'd1,	// low byte only
		rl_msb   = 2'd2,	// high byte only
		rl_both  = 2'd3	// low byte then high byte
	} pit_rl_t;

	// position of the loader or the reader inside a count
	typedef enum logic [2:0] {
		byte_none      = 3'd0,	// single byte live access
		byte_lsb_next  = 3'd1,	// loader waits for low byte
		byte_msb_next  = 3'd2,	// high byte comes next
		byte_latch_lsb = 3'd3,	// latched count, low byte pending
		byte_latch_msb = 3'd4	// latched count, high byte pending
	} pit_byte_t;

endpackage

// ==== hw/pit_bus_pkg.sv ====
//--------------------------------------------------------------------------
// PIT host bus definitions
// Register address map and the widths of the bus byte and the count
//--------------------------------------------------------------------------

package pit_bus_pkg;

	parameter int data_width  = 8;	// host bus byte
	parameter int count_width = 16;	// counter width

	// two bit register address
	typedef enum logic [1:0] {
		addr_cnt0 = 2'd0,	// counter 0 count
		addr_cnt1 = 2'd1,	// counter 1 count
		addr_cnt2 = 2'd2,	// counter 2 count
		addr_ctrl = 2'd3	// control word, write only
	} pit_addr_t;

endpackage

// ==== hw/pit_chan_if.sv ====
//--------------------------------------------------------------------------
// PIT channel bus link
// Per channel strobes and data between the bus decoder and one counter
// channel
//--------------------------------------------------------------------------

interface pit_chan_if
	import pit_bus_pkg::*;
();

	logic                  cw_set;	// control word for this channel
	logic                  load_wr;	// count byte written
	logic                  read_rd;	// count byte read
	logic [data_width-1:0] wdata;	// bus byte
	logic [data_width-1:0] rdata;	// channel read byte

	modport decoder (
		output cw_set,
		output load_wr,
		output read_rd,
		output wdata,
		input  rdata
	);

	modport channel (
		input  cw_set,
		input  load_wr,
		input  read_rd,
		input  wdata,
		output rdata
	);

endinterface

// ==== hw/pit_down_counter.sv ====
//--------------------------------------------------------------------------
// PIT down counter
// Reloadable binary counter that steps once per enabled tce. Steps by two
// in square wave mode with an odd count fix-up that depends on out
//--------------------------------------------------------------------------

module pit_down_counter
	import pit_bus_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   step_en,	// gated tce
	input  logic                   half_step,	// square wave counting
	input  logic                   out_level,	// current out for odd counts
	input  logic                   load,	// take load_value this step
	input  logic [count_width-1:0] load_value,
	output logic [count_width-1:0] count
);

	logic [count_width-1:0] step;	// amount taken off per step

	// odd counts in half step mode
	// minus one while high gives the longer high phase
	// minus three while low gives the shorter low phase
	always_comb begin
		if (!half_step)
			step = count_width'(1);
		else if (!count[0])
			step = count_width'(2);	// even count
		else if (out_level)
			step = count_width'(1);
		else
			step = count_width'(3);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (step_en) begin
			if (load)
				count <= load_value;	// start or reload
			else
				count <= count - step;	// wraps below zero
		end
	end

endmodule

// ==== hw/pit_counter_channel.sv ====
//--------------------------------------------------------------------------
// PIT counter channel
// Control register, count load and read byte sequencing, counter latch
// and the mode dependent output waveform for one timer channel
//--------------------------------------------------------------------------

module pit_counter_channel
	import pit_mode_pkg::*, pit_bus_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        tce,
	output logic        out,
	pit_chan_if.channel bus
);

	localparam int hi_width = count_width - data_width;

	pit_mode_t              cw_mode;	// active mode
	pit_rl_t                rl_mode;	// active read/load format
	pit_byte_t              load_seq;	// loader position
	pit_byte_t              read_seq;	// reader position
	pit_mode_t              cw_new_mode;	// mode carried by incoming word
	logic                   cw_is_latch;	// incoming word is a latch command
	logic [count_width-1:0] count_load;	// programmed count
	logic [count_width-1:0] count_latch;	// frozen copy for latch reads
	logic [count_width-1:0] count;	// live counter value
	logic                   loaded;	// counting allowed
	logic                   half_loaded;	// low byte in, high byte missing
	logic                   load_pending;	// next step loads count_load
	logic                   latched;	// latch waiting to be read
	logic                   load_complete;	// last byte of a count written
	logic                   counting_mode;	// mode that counts at all
	logic                   restart_mode;	// new count restarts at once
	logic                   square_term;	// mode 3 half period end
	logic                   step_en;
	logic                   reload_now;

	//--------------------------------------------------------------------------
	// decode
	//--------------------------------------------------------------------------
	assign cw_new_mode = (bus.wdata[3:2] == 2'b11) ? pit_mode_t'({1'b0, bus.wdata[2:1]})
		: pit_mode_t'(bus.wdata[3:1]);	// 6 and 7 alias to 2 and 3
	assign cw_is_latch = (bus.wdata[5:4] == rl_latch);

	assign latched       = (read_seq == byte_latch_lsb) || (read_seq == byte_latch_msb);
	assign load_complete = bus.load_wr && (rl_mode != rl_both || load_seq == byte_msb_next);
	assign counting_mode = (cw_mode != mode_one_shot) && (cw_mode != mode_hw_strobe);
	assign restart_mode  = (cw_mode == mode_int_tc) || (cw_mode == mode_sw_strobe);

	// odd count 3 in the low phase never passes through 2
	assign square_term = (count == count_width'(2)) || (count == count_width'(3) && !out);

	assign step_en    = tce & loaded & ~half_loaded;	// frozen mid load
	assign reload_now = load_pending
		|| (cw_mode == mode_rate && count == count_width'(1))
		|| (cw_mode == mode_square && square_term);

	pit_down_counter counter (
		.clk        (clk),
		.reset      (reset),
		.step_en    (step_en),
		.half_step  (cw_mode == mode_square),
		.out_level  (out),
		.load       (reload_now),
		.load_value (count_load),
		.count      (count)
	);

	//--------------------------------------------------------------------------
	// control state and output
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cw_mode      <= mode_one_shot;	// unprogrammed
			rl_mode      <= rl_lsb;
			load_seq     <= byte_lsb_next;
			read_seq     <= byte_none;
			loaded       <= 1'b0;
			half_loaded  <= 1'b0;
			load_pending <= 1'b0;
			out          <= 1'b1;
		end else begin
			if (tce && cw_mode == mode_sw_strobe && !out)
				out <= 1'b1;	// strobe lasts one tce
			if (step_en) begin
				if (load_pending) begin
					load_pending <= 1'b0;	// counter takes the count now
				end else begin
					case (cw_mode)
						mode_int_tc: begin
							if (count == count_width'(1)) begin
								out    <= 1'b1;	// reaches zero
								loaded <= 1'b0;
							end
						end
						mode_rate: out <= (count != count_width'(2));	// low while at 1
						mode_square: begin
							if (square_term)
								out <= ~out;
						end
						mode_sw_strobe: begin
							if (count == count_width'(1)) begin
								out    <= 1'b0;	// strobe at zero
								loaded <= 1'b0;
							end
						end
						default: ;
					endcase
				end
			end

			// bus side wins over the timer side
			if (bus.cw_set) begin
				if (cw_is_latch) begin
					if (!latched)
						read_seq <= byte_latch_lsb;	// later latches ignored
				end else begin
					cw_mode      <= cw_new_mode;
					rl_mode      <= pit_rl_t'(bus.wdata[5:4]);
					load_seq     <= byte_lsb_next;
					read_seq     <= byte_none;
					loaded       <= 1'b0;
					half_loaded  <= 1'b0;
					load_pending <= 1'b0;
					out          <= (cw_new_mode != mode_int_tc);
				end
			end
			if (bus.load_wr && rl_mode == rl_both) begin
				half_loaded <= (load_seq == byte_lsb_next);
				load_seq    <= (load_seq == byte_lsb_next) ? byte_msb_next : byte_lsb_next;
			end
			if (load_complete && counting_mode) begin
				if (restart_mode || !loaded) begin	// modes 2 and 3 pick it up at reload
					loaded       <= 1'b1;
					load_pending <= 1'b1;
				end
				if (cw_mode == mode_int_tc)
					out <= 1'b0;
			end
			if (bus.read_rd) begin
				case (read_seq)
					byte_latch_lsb: read_seq <= byte_latch_msb;
					byte_latch_msb: read_seq <= byte_none;	// latch released
					byte_msb_next:  read_seq <= byte_none;
					default: begin
						if (rl_mode == rl_both)
							read_seq <= byte_msb_next;
					end
				endcase
			end
		end
	end

	//--------------------------------------------------------------------------
	// count bytes
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (bus.load_wr) begin
			case (rl_mode)
				rl_lsb: count_load <= {{hi_width{1'b0}}, bus.wdata};
				rl_msb: count_load <= {bus.wdata, {data_width{1'b0}}};
				rl_both: begin
					if (load_seq == byte_lsb_next)
						count_load[data_width-1:0] <= bus.wdata;
					else
						count_load[count_width-1:data_width] <= bus.wdata;
				end
				default: ;
			endcase
		end
		if (bus.cw_set && cw_is_latch && !latched)
			count_latch <= count;	// snapshot of live count
	end

	always_comb begin
		case (read_seq)
			byte_latch_lsb: bus.rdata = count_latch[data_width-1:0];
			byte_latch_msb: bus.rdata = count_latch[count_width-1:data_width];
			byte_msb_next:  bus.rdata = count[count_width-1:data_width];
			default:        bus.rdata = (rl_mode == rl_msb) ? count[count_width-1:data_width]
				: count[data_width-1:0];
		endcase
	end

endmodule

// ==== hw/pit_bus_decode.sv ====
//--------------------------------------------------------------------------
// PIT bus decoder
// Samples the host bus and turns each access into one cycle strobes for
// the addressed channel, then returns the channel's read byte on data_out
// one cycle later
//--------------------------------------------------------------------------

module pit_bus_decode
	import pit_bus_pkg::*;
#(
	parameter int num_channels = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,
	input  pit_addr_t             addr,
	input  logic                  wr,
	input  logic                  rd,
	input  logic [data_width-1:0] data_in,
	output logic [data_width-1:0] data_out,
	pit_chan_if.decoder           chan [num_channels]
);

	logic                    bus_wr;	// qualified write
	logic                    bus_rd;	// qualified read
	logic [num_channels-1:0] cw_q;	// control word strobes
	logic [num_channels-1:0] load_q;	// count byte write strobes
	logic [num_channels-1:0] read_q;	// count byte read strobes
	logic                    rd_q;	// any read seen last cycle
	logic [data_width-1:0]   wdata_q;	// sampled bus byte
	logic [data_width-1:0]   rdata_all [num_channels];
	logic [data_width-1:0]   read_byte;	// byte of the channel being read

	assign bus_wr = ce & wr;
	assign bus_rd = ce & rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			cw_q   <= '0;
			load_q <= '0;
			read_q <= '0;
			rd_q   <= 1'b0;
			data_out <= '0;
		end else begin
			for (int i = 0; i < num_channels; i++) begin
				cw_q[i]   <= bus_wr && addr == addr_ctrl && data_in[data_width-1 -: 2] == 2'(i);
				load_q[i] <= bus_wr && addr == pit_addr_t'(i);
				read_q[i] <= bus_rd && addr == pit_addr_t'(i);
			end
			rd_q <= bus_rd;
			if (rd_q)
				data_out <= read_byte;	// ctrl or missing channel gives zero
		end
	end

	always_ff @(posedge clk) begin
		if (bus_wr)
			wdata_q <= data_in;
	end

	// at most one read strobe is high
	always_comb begin
		read_byte = '0;
		for (int i = 0; i < num_channels; i++) begin
			if (read_q[i])
				read_byte = rdata_all[i];
		end
	end

	for (genvar i = 0; i < num_channels; i++) begin : g_link
		assign chan[i].cw_set  = cw_q[i];
		assign chan[i].load_wr = load_q[i];
		assign chan[i].read_rd = read_q[i];
		assign chan[i].wdata   = wdata_q;
		assign rdata_all[i]    = chan[i].rdata;
	end

endmodule

// ==== hw/pit_timer.sv ====
//--------------------------------------------------------------------------
// PIT timer top level
// Three channel programmable interval timer in the style of the 8253.
// One bus decoder feeds num_channels counter channels that share the
// timer clock enable tce
//--------------------------------------------------------------------------

module pit_timer
	import pit_bus_pkg::*;
#(
	parameter int num_channels = 3	// one to three
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    ce,	// bus clock enable
	input  logic                    tce,	// timer clock enable
	input  logic [1:0]              addr,	// register address
	input  logic                    wr,
	input  logic                    rd,
	input  logic [data_width-1:0]   data_in,
	output logic [data_width-1:0]   data_out,
	output logic [num_channels-1:0] out	// one pin per channel
);

	pit_chan_if chan_bus [num_channels] ();	// decoder to channel links

	pit_bus_decode #(
		.num_channels (num_channels)
	) bus_decode (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.addr     (pit_addr_t'(addr)),
		.wr       (wr),
		.rd       (rd),
		.data_in  (data_in),
		.data_out (data_out),
		.chan     (chan_bus)
	);

	for (genvar i = 0; i < num_channels; i++) begin : g_chan
		pit_counter_channel channel (
			.clk   (clk),
			.reset (reset),
			.tce   (tce),
			.out   (out[i]),
			.bus   (chan_bus[i])
		);
	end

endmodule

// ==== verif/pit_tb_table.svh ====
//--------------------------------------------------------------------------
// PIT timer test table
// One row per step for a bus write or read, a tce burst with a masked out
// check, an out period or high time measurement, or a random count byte
//--------------------------------------------------------------------------

`ifndef pit_tb_table_svh
`define pit_tb_table_svh

typedef enum logic [2:0] {
	op_write,	// bus write of data
	op_read,	// bus read, data_out against exp_val
	op_run,	// tce pulses then out & data[2:0] against exp_val
	op_period,	// tce pulses between rising edges of out[addr]
	op_high,	// tce pulses from a rising to the next falling edge
	op_wr_rand,	// bus write of a fresh random byte
	op_rd_rand	// bus read against the last random byte
} tb_op_t;

typedef struct packed {
	tb_op_t                op;
	pit_addr_t             addr;	// register, or channel for measures
	logic [data_width-1:0] data;	// write byte or out mask
	logic [7:0]            tces;	// pulses to run, or measure window
	logic [15:0]           exp_val;
} tb_step_t;

localparam int num_steps = 49;

localparam tb_step_t steps [num_steps] = '{
	'{op_run,     addr_cnt0, 8'h07, 8'd0,  16'h0007},	// all outs high after reset
	'{op_read,    addr_cnt0, 8'h00, 8'd0,  16'h0000},	// unprogrammed reads zero
	'{op_write,   addr_ctrl, 8'h30, 8'd0,  16'h0000},	// ch0 mode 0, lsb then msb
	'{op_run,     addr_cnt0, 8'h07, 8'd0,  16'h0006},	// only out0 drops
	'{op_write,   addr_cnt0, 8'h34, 8'd0,  16'h0000},
	'{op_write,   addr_cnt0, 8'h12, 8'd0,  16'h0000},	// N = 0x1234
	'{op_run,     addr_cnt0, 8'h07, 8'd6,  16'h0006},	// load plus five steps
	'{op_write,   addr_ctrl, 8'h00, 8'd0,  16'h0000},	// latch ch0
	'{op_run,     addr_cnt0, 8'h01, 8'd3,  16'h0000},	// still counting with out0 low
	'{op_read,    addr_cnt0, 8'h00, 8'd0,  16'h002f},	// low byte of 0x1234 minus 5
	'{op_read,    addr_cnt0, 8'h00, 8'd0,  16'h0012},
	'{op_write,   addr_ctrl, 8'h70, 8'd0,  16'h0000},	// ch1 mode 0
	'{op_write,   addr_cnt1, 8'h05, 8'd0,  16'h0000},
	'{op_write,   addr_cnt1, 8'h00, 8'd0,  16'h0000},	// N = 5
	'{op_run,     addr_cnt0, 8'h02, 8'd5,  16'h0000},	// low through N pulses
	'{op_run,     addr_cnt0, 8'h02, 8'd1,  16'h0002},	// high after pulse N+1
	'{op_write,   addr_ctrl, 8'h36, 8'd0,  16'h0000},	// ch0 mode 3
	'{op_write,   addr_cnt0, 8'h04, 8'd0,  16'h0000},
	'{op_write,   addr_cnt0, 8'h00, 8'd0,  16'h0000},	// even N = 4
	'{op_write,   addr_ctrl, 8'h74, 8'd0,  16'h0000},	// ch1 mode 2
	'{op_write,   addr_cnt1, 8'h04, 8'd0,  16'h0000},
	'{op_write,   addr_cnt1, 8'h00, 8'd0,  16'h0000},	// N = 4
	'{op_write,   addr_ctrl, 8'hb6, 8'd0,  16'h0000},	// ch2 mode 3
	'{op_write,   addr_cnt2, 8'h05, 8'd0,  16'h0000},
	'{op_write,   addr_cnt2, 8'h00, 8'd0,  16'h0000},	// odd N = 5
	'{op_period,  addr_cnt1, 8'h00, 8'd14, 16'h0004},	// rate period N
	'{op_period,  addr_cnt2, 8'h00, 8'd17, 16'h0005},	// square period N
	'{op_high,    addr_cnt2, 8'h00, 8'd17, 16'h0003},	// (N+1)/2 high
	'{op_high,    addr_cnt0, 8'h00, 8'd14, 16'h0002},	// N/2 high
	'{op_period,  addr_cnt0, 8'h00, 8'd14, 16'h0004},	// even square period N
	'{op_write,   addr_ctrl, 8'h90, 8'd0,  16'h0000},	// ch2 mode 0, lsb only
	'{op_wr_rand, addr_cnt2, 8'h00, 8'd0,  16'h0000},
	'{op_run,     addr_cnt0, 8'h04, 8'd1,  16'h0000},	// load only
	'{op_rd_rand, addr_cnt2, 8'h00, 8'd0,  16'h0000},
	'{op_write,   addr_ctrl, 8'ha0, 8'd0,  16'h0000},	// ch2 mode 0, msb only
	'{op_wr_rand, addr_cnt2, 8'h00, 8'd0,  16'h0000},
	'{op_run,     addr_cnt0, 8'h04, 8'd1,  16'h0000},
	'{op_rd_rand, addr_cnt2, 8'h00, 8'd0,  16'h0000},
	'{op_write,   addr_ctrl, 8'h38, 8'd0,  16'h0000},	// ch0 mode 4
	'{op_write,   addr_cnt0, 8'h03, 8'd0,  16'h0000},
	'{op_write,   addr_cnt0, 8'h00, 8'd0,  16'h0000},	// N = 3
	'{op_run,     addr_cnt0, 8'h01, 8'd3,  16'h0001},	// high before zero
	'{op_run,     addr_cnt0, 8'h01, 8'd1,  16'h0000},	// strobe at zero
	'{op_run,     addr_cnt0, 8'h01, 8'd1,  16'h0001},	// one tce long
	'{op_run,     addr_cnt0, 8'h01, 8'd4,  16'h0001},	// no second strobe
	'{op_write,   addr_cnt0, 8'h03, 8'd0,  16'h0000},
	'{op_write,   addr_cnt0, 8'h00, 8'd0,  16'h0000},	// retrigger
	'{op_run,     addr_cnt0, 8'h01, 8'd4,  16'h0000},
	'{op_run,     addr_cnt0, 8'h01, 8'd1,  16'h0001}
};

`endif

// ==== verif/pit_timer_tb.sv ====
//--------------------------------------------------------------------------
// PIT timer testbench
// Runs the step table against the timer with bus writes and reads, tce
// bursts with out checks, and out period and high time measurement
//--------------------------------------------------------------------------

module pit_timer_tb
	import pit_bus_pkg::*;
();

	`include "pit_tb_table.svh"

	localparam int half_period = 2;	// clock period 4
	localparam int margin      = 64;	// reset and slack

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  ce;
	logic                  tce;
	logic [1:0]            addr;
	logic                  wr;
	logic                  rd;
	logic [data_width-1:0] data_in;
	logic [data_width-1:0] data_out;
	logic [2:0]            out;
	integer                seed = 32'h56c60d83;	// $random state
	logic [data_width-1:0] rand_byte;	// last random count byte
	int                    cycles = 0;
	int                    cycle_limit;

	pit_timer #(
		.num_channels (3)
	) dut0 (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.tce      (tce),
		.addr     (addr),
		.wr       (wr),
		.rd       (rd),
		.data_in  (data_in),
		.data_out (data_out),
		.out      (out)
	);

	always #half_period clk = ~clk;

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERROR at time %0t: %s expected %h, got %h", $time, name, expected,
				actual);
			stop_on_failure("a checked value did not match");
		end
	endtask

	// starts and ends on a falling edge with data_out valid on return
	task automatic bus_access(input logic write, input logic [1:0] a,
		input logic [data_width-1:0] d);
		ce      = 1'b1;
		wr      = write;
		rd      = ~write;
		addr    = a;
		data_in = d;
		@(negedge clk);	// sampled by the decoder
		ce = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		@(negedge clk);	// channel acted and read byte out
	endtask

	task automatic tce_pulse();
		tce = 1'b1;
		@(negedge clk);
		tce = 1'b0;
		@(negedge clk);	// spacing between pulses
	endtask

	// pulses from a rising edge of out[ch] to the next rising edge,
	// or to the next falling edge for a high time
	task automatic measure_out(input int ch, input int window, input logic high_only,
		output int result);
		int   rise_at;
		logic prev;
		rise_at = -1;
		result  = -1;
		prev    = out[ch];
		for (int i = 1; i <= window && result < 0; i++) begin
			tce_pulse();
			if (out[ch] != prev) begin
				if (rise_at >= 0 && out[ch] == !high_only)
					result = i - rise_at;
				else if (out[ch])
					rise_at = i;	// first rise opens the window
			end
			prev = out[ch];
		end
		if (result < 0)
			stop_on_failure("no full out cycle was seen within the measure window");
	endtask

	// ---------------------------------------------------------------------
	// timeout
	// ---------------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			stop_on_failure("the run went past its cycle limit without finishing");
	end

	// ---------------------------------------------------------------------
	// step table
	// ---------------------------------------------------------------------
	initial begin
		tb_step_t step;
		int       measured;
		reset   = 1'b1;
		ce      = 1'b0;
		tce     = 1'b0;
		addr    = 2'd0;
		wr      = 1'b0;
		rd      = 1'b0;
		data_in = '0;
		cycle_limit = margin;
		for (int i = 0; i < num_steps; i++)
			cycle_limit += 2 + 2 * int'(steps[i].tces);	// bus op or tce spacing
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < num_steps; i++) begin
			step = steps[i];
			case (step.op)
				op_write: bus_access(1'b1, step.addr, step.data);
				op_read: begin
					bus_access(1'b0, step.addr, 8'h00);
					check_value("data_out", step.exp_val, {8'h00, data_out});
				end
				op_run: begin
					repeat (step.tces) tce_pulse();
					check_value("out", step.exp_val, {13'd0, out & step.data[2:0]});
				end
				op_period, op_high: begin
					measure_out(int'(step.addr), int'(step.tces), step.op == op_high,
						measured);
					if (step.op == op_high)
						check_value("out high time", step.exp_val, 16'(measured));
					else
						check_value("out period", step.exp_val, 16'(measured));
				end
				op_wr_rand: begin
					rand_byte = 8'($random(seed));
					bus_access(1'b1, step.addr, rand_byte);
				end
				op_rd_rand: begin
					bus_access(1'b0, step.addr, 8'h00);
					check_value("data_out", {8'h00, rand_byte}, {8'h00, data_out});
				end
				default: stop_on_failure("the step table holds an unknown operation");
			endcase
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+verif
hw/pit_mode_pkg.sv
hw/pit_bus_pkg.sv
hw/pit_chan_if.sv
hw/pit_down_counter.sv
hw/pit_counter_channel.sv
hw/pit_bus_decode.sv
hw/pit_timer.sv
verif/pit_timer_tb.sv

// ==== Makefile ====
# Verilator build and run of the PIT timer testbench

VERILATOR = verilator
TOP       = pit_timer_tb
FILELIST  = sources.f
VFLAGS    = --binary -j 0 --top-module $(TOP)
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) verif/pit_tb_table.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
